/* common/dragonPkg.sv */
package dragonPkg;

	// frame pacing shortened for simulation
	localparam int FRAME_CYCLES = 16;
	localparam int FRAME_CNT_W = $clog2(FRAME_CYCLES);

	// widths of the fixed-point, pixel and random values
	localparam int FIX_W = 32;
	localparam int PIX_W = 11;
	localparam int RND_W = 12;

	// position carries 6 fractional bits
	localparam int FIXED_SHIFT = 6;

	localparam int START_X = 680;
	localparam int START_Y = 60;

	// per-frame steps in 1/64 pixel
	localparam int X_SPEED = -120;
	localparam int Y_SPEED = 70;

	// vertical band the dragon bounces in
	localparam int Y_MIN = 20;
	localparam int Y_MAX = 180;

	// dragon is gone once it reaches this column
	localparam int EXIT_X = -50;

	// open windows on the random sum
	localparam int SPAWN_LO = 600;
	localparam int SPAWN_HI = 640;
	localparam int FLIP_LO = 300;
	localparam int FLIP_HI = 600;

	localparam int RAND_COUNT = 10;
	localparam int RAND_IDX_W = $clog2(RAND_COUNT);
	localparam logic [PIX_W-1:0] RAND_SEED = 11'h2c5;
	localparam logic [RAND_COUNT-1:0][PIX_W-1:0] RAND_OFFSETS = {
		11'd6, 11'd501, 11'd80, 11'd100, 11'd140,
		11'd18, 11'd44, 11'd340, 11'd210, 11'd277
	};

	typedef enum logic {
		sIdle,
		sFlying
	} dragonStateT;

	typedef struct packed {
		logic signed [PIX_W-1:0] x;
		logic signed [PIX_W-1:0] y;
		logic flying;
	} dragonPosT;

endpackage

/* hw/frameTimer.sv */
`timescale 1ns/10ps

module frameTimer import dragonPkg::*; (
	input logic clk,
	input logic resetN,
	output logic frameTick
);

	logic [FRAME_CNT_W-1:0] cycleCnt;
	logic wrap;

	assign wrap = (cycleCnt == FRAME_CNT_W'(FRAME_CYCLES - 1));

	// tick is registered, so it shows one cycle after the wrap count
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			cycleCnt <= '0;
			frameTick <= 1'b0;
		end else begin
			frameTick <= wrap;
			if (wrap) begin
				cycleCnt <= '0;
			end else begin
				cycleCnt <= cycleCnt + 1'b1;
			end
		end
	end

endmodule

/* hw/lfsrRng.sv */
`timescale 1ns/10ps

module lfsrRng import dragonPkg::*; (
	input logic clk,
	input logic resetN,
	input logic frameTick,
	output logic [RND_W-1:0] rndSum
);

	logic [PIX_W-1:0] lfsr;
	logic [RAND_IDX_W-1:0] offsetIdx;
	logic feedback;
	logic lastIdx;

	// taps of the maximal-length x^11 + x^9 + 1 polynomial
	assign feedback = lfsr[PIX_W-1] ^ lfsr[PIX_W-3];

	assign lastIdx = (offsetIdx == RAND_IDX_W'(RAND_COUNT - 1));

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			lfsr <= RAND_SEED;
			offsetIdx <= '0;
		end else if (frameTick) begin
			lfsr <= {lfsr[PIX_W-2:0], feedback};
			if (lastIdx) begin
				offsetIdx <= '0;
			end else begin
				offsetIdx <= offsetIdx + 1'b1;
			end
		end
	end

	// table offset breaks up the plain LFSR pattern
	assign rndSum = RND_W'(lfsr) + RND_W'(RAND_OFFSETS[offsetIdx]);

endmodule

/* dragon/dragonSpawnFsm.sv */
`timescale 1ns/10ps

module dragonSpawnFsm import dragonPkg::*; (
	input logic clk,
	input logic resetN,
	input logic frameTick,
	input logic [RND_W-1:0] rndSum,
	input dragonPosT pos,
	output logic flying
);

	dragonStateT state;
	dragonStateT stateNext;
	logic spawnHit;
	logic exitHit;

	// release only inside the open spawn window
	assign spawnHit = (rndSum > SPAWN_LO) && (rndSum < SPAWN_HI);

	// last report reached the left edge
	assign exitHit = (pos.x <= EXIT_X);

	always_comb begin
		stateNext = state;
		if (frameTick) begin
			unique case (state)
				sIdle: begin
					if (spawnHit) begin
						stateNext = sFlying;
					end
				end
				sFlying: begin
					if (exitHit) begin
						stateNext = sIdle;
					end
				end
				default: begin
					stateNext = sIdle;
				end
			endcase
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			state <= sIdle;
		end else begin
			state <= stateNext;
		end
	end

	assign flying = (state == sFlying);

endmodule

/* dragon/dragonMover.sv */
`timescale 1ns/10ps

module dragonMover import dragonPkg::*; (
	input logic clk,
	input logic resetN,
	input logic frameTick,
	input logic flying,
	input logic pause,
	input logic [RND_W-1:0] rndSum,
	input logic posReady,
	output dragonPosT pos,
	output logic posValid
);

	logic signed [FIX_W-1:0] xFix;
	logic signed [FIX_W-1:0] yFix;
	logic signed [FIX_W-1:0] ySpeed;
	logic signed [FIX_W-1:0] ySpeedNext;
	logic signed [PIX_W-1:0] xPix;
	logic signed [PIX_W-1:0] yPix;
	logic reportFlying;
	logic accept;
	logic leaving;
	logic flipHit;

	// pixel view of the fixed-point position
	assign xPix = PIX_W'(xFix >>> FIXED_SHIFT);
	assign yPix = PIX_W'(yFix >>> FIXED_SHIFT);

	// a tick is dropped while the previous report still waits
	assign accept = frameTick && (!posValid || posReady);

	// exit frame goes back to start on the same tick the FSM returns to idle
	assign leaving = flying && (xPix <= EXIT_X);

	assign flipHit = (rndSum > FLIP_LO) && (rndSum < FLIP_HI);

	// bounce off the band edges and flip at random inside it
	always_comb begin
		ySpeedNext = ySpeed;
		if (yPix < Y_MIN) begin
			ySpeedNext = Y_SPEED;
		end else if (yPix > Y_MAX) begin
			ySpeedNext = -Y_SPEED;
		end else if (flipHit) begin
			ySpeedNext = -ySpeed;
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			xFix <= START_X <<< FIXED_SHIFT;
			yFix <= START_Y <<< FIXED_SHIFT;
			ySpeed <= Y_SPEED;
			reportFlying <= 1'b0;
		end else if (accept) begin
			if (!flying || leaving) begin
				xFix <= START_X <<< FIXED_SHIFT;
				yFix <= START_Y <<< FIXED_SHIFT;
				ySpeed <= Y_SPEED;
				reportFlying <= 1'b0;
			end else if (!pause) begin
				ySpeed <= ySpeedNext;
				xFix <= xFix + X_SPEED;
				yFix <= yFix + ySpeedNext;
				reportFlying <= 1'b1;
			end else begin
				// paused in flight so the same spot is reported again
				reportFlying <= 1'b1;
			end
		end
	end

	// report handshake
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			posValid <= 1'b0;
		end else if (accept) begin
			posValid <= 1'b1;
		end else if (posReady) begin
			posValid <= 1'b0;
		end
	end

	// registers only move on an accepted tick, so pos holds under back-pressure
	assign pos = '{x: xPix, y: yPix, flying: reportFlying};

endmodule

/* hw/dragonTop.sv */
`timescale 1ns/10ps

module dragonTop import dragonPkg::*; (
	input logic clk,
	input logic resetN,
	input logic pause,
	input logic posReady,
	output dragonPosT pos,
	output logic posValid
);

	logic frameTick;
	logic [RND_W-1:0] rndSum;
	logic flying;

	frameTimer i_frameTimer (
		.clk(clk),
		.resetN(resetN),
		.frameTick(frameTick)
	);

	lfsrRng i_lfsrRng (
		.clk(clk),
		.resetN(resetN),
		.frameTick(frameTick),
		.rndSum(rndSum)
	);

	// exit test reads back the reported position
	dragonSpawnFsm i_dragonSpawnFsm (
		.clk(clk),
		.resetN(resetN),
		.frameTick(frameTick),
		.rndSum(rndSum),
		.pos(pos),
		.flying(flying)
	);

	dragonMover i_dragonMover (
		.clk(clk),
		.resetN(resetN),
		.frameTick(frameTick),
		.flying(flying),
		.pause(pause),
		.rndSum(rndSum),
		.posReady(posReady),
		.pos(pos),
		.posValid(posValid)
	);

endmodule

/* test/dragonTb_assert.sv */
`timescale 1ns/10ps

module dragonTb_assert import dragonPkg::*; (
	input logic clk,
	input logic resetN,
	input logic frameTick,
	input logic pause,
	input logic posReady,
	input dragonPosT pos,
	input logic posValid
);

	int failCount = 0;
	int hitReset = 0;
	int hitIdle = 0;
	int hitStep = 0;
	int hitBand = 0;
	int hitHeld = 0;
	int hitStall = 0;
	int hitExit = 0;

	logic wasReset;
	logic pauseRun;
	logic skipSeen;
	logic repPaused;
	logic repHeld;
	logic repSkip;
	logic prevValid;
	dragonPosT prevPos;
	logic accept;
	logic xfer;
	logic stall;
	logic stepCase;
	logic heldCase;
	logic exitCase;
	logic signed [PIX_W:0] dx;
	logic signed [PIX_W:0] dy;

	// a tick is taken only when no report is left waiting
	assign accept = frameTick && (!posValid || posReady);
	assign xfer = posValid && posReady;
	assign stall = posValid && !posReady;
	assign dx = (PIX_W+1)'(pos.x) - (PIX_W+1)'(prevPos.x);
	assign dy = (PIX_W+1)'(pos.y) - (PIX_W+1)'(prevPos.y);
	assign stepCase = xfer && pos.flying && prevValid && prevPos.flying && !repPaused && !repSkip;
	assign heldCase = xfer && pos.flying && prevValid && repHeld;
	assign exitCase = xfer && prevValid && prevPos.flying && (prevPos.x <= EXIT_X);

	// shadow of the offered report and of the last transferred one
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			wasReset <= 1'b1;
			pauseRun <= 1'b0;
			skipSeen <= 1'b0;
			repPaused <= 1'b0;
			repHeld <= 1'b0;
			repSkip <= 1'b0;
			prevValid <= 1'b0;
			prevPos <= '0;
		end else begin
			wasReset <= 1'b0;
			// new frame starts right after each tick
			pauseRun <= frameTick || (pauseRun && pause);
			if (xfer) begin
				prevValid <= 1'b1;
				prevPos <= pos;
			end
			if (accept) begin
				repPaused <= pause;
				repHeld <= pauseRun && pause;
				repSkip <= skipSeen;
				skipSeen <= 1'b0;
			end else if (frameTick) begin
				skipSeen <= 1'b1;
			end
		end
	end

	always @(posedge clk) begin
		if (wasReset) hitReset <= hitReset + 1;
		if (resetN) begin
			if (xfer && !pos.flying) hitIdle <= hitIdle + 1;
			if (stepCase) hitStep <= hitStep + 1;
			if (xfer && pos.flying) hitBand <= hitBand + 1;
			if (heldCase) hitHeld <= hitHeld + 1;
			if (stall) hitStall <= hitStall + 1;
			if (exitCase) hitExit <= hitExit + 1;
		end
	end

	task automatic flagFailure(input string msg);
		failCount++;
		$error("%s", msg);
	endtask

	aReset: assert property (@(posedge clk)
		wasReset |-> !posValid && pos.x == START_X && pos.y == START_Y)
		else flagFailure($sformatf("Fail pos after reset: posValid %h x %h y %h",
			$sampled(posValid), $sampled(pos.x), $sampled(pos.y)));

	aIdle: assert property (@(posedge clk) disable iff (!resetN)
		xfer && !pos.flying |-> pos.x == START_X && pos.y == START_Y)
		else flagFailure($sformatf("Fail pos idle report: x %h y %h",
			$sampled(pos.x), $sampled(pos.y)));

	aStep: assert property (@(posedge clk) disable iff (!resetN)
		stepCase |-> (dx == -1 || dx == -2) && dy >= -2 && dy <= 2)
		else flagFailure($sformatf("Fail pos step: x %h to %h, y %h to %h",
			$sampled(prevPos.x), $sampled(pos.x), $sampled(prevPos.y), $sampled(pos.y)));

	aBand: assert property (@(posedge clk) disable iff (!resetN)
		xfer && pos.flying |-> pos.y >= Y_MIN - 2 && pos.y <= Y_MAX + 2)
		else flagFailure($sformatf("Fail pos.y out of band: %h", $sampled(pos.y)));

	aHeld: assert property (@(posedge clk) disable iff (!resetN)
		heldCase |-> pos.x == prevPos.x && pos.y == prevPos.y)
		else flagFailure($sformatf("Fail pos while paused: x %h to %h, y %h to %h",
			$sampled(prevPos.x), $sampled(pos.x), $sampled(prevPos.y), $sampled(pos.y)));

	aStall: assert property (@(posedge clk) disable iff (!resetN)
		stall |=> posValid && pos == $past(pos))
		else flagFailure("report was dropped or changed while posReady was low");

	aExit: assert property (@(posedge clk) disable iff (!resetN)
		exitCase |-> !pos.flying && pos.x == START_X && pos.y == START_Y)
		else flagFailure($sformatf("Fail pos after exit: flying %h x %h y %h",
			$sampled(pos.flying), $sampled(pos.x), $sampled(pos.y)));

endmodule

/* test/dragonTb.sv */
`timescale 1ns/10ps

module dragonTb import dragonPkg::*; ();

	localparam logic [31:0] RNG_SEED = 32'h18e4;
	// frames for one crossing from START_X to EXIT_X
	localparam int FLIGHT_FRAMES = ((START_X - EXIT_X) << FIXED_SHIFT) / (-X_SPEED) + 2;
	// every LFSR and table pairing comes up once in this many frames
	localparam int SPAWN_FRAMES = ((1 << PIX_W) - 1) * RAND_COUNT;
	localparam int PAUSE_WINDOWS = 3;
	localparam int PAUSE_FRAMES = 4;
	localparam int GAP_FRAMES = 6;
	localparam int MIN_STEPS = 20;
	localparam int TIMEOUT_CYCLES = (SPAWN_FRAMES + FLIGHT_FRAMES
		+ PAUSE_WINDOWS * (PAUSE_FRAMES + GAP_FRAMES) + 16) * FRAME_CYCLES;

	logic clk;
	logic resetN;
	logic pause;
	logic posReady;
	dragonPosT pos;
	logic posValid;

	logic [31:0] rngState;
	int cycleCount = 0;
	int phaseFails;
	int missing;

	dragonTop i_dut (
		.clk(clk),
		.resetN(resetN),
		.pause(pause),
		.posReady(posReady),
		.pos(pos),
		.posValid(posValid)
	);

	bind dragonTop dragonTb_assert i_checks (
		.clk(clk),
		.resetN(resetN),
		.frameTick(frameTick),
		.pause(pause),
		.posReady(posReady),
		.pos(pos),
		.posValid(posValid)
	);

	function automatic logic [31:0] lcgNext(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic waitCycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic finishPhase(input string name, input int hits);
		$display("%s phase done: %0d checks reached, %0d assertion failures", name, hits,
			i_dut.i_checks.failCount - phaseFails);
		phaseFails = i_dut.i_checks.failCount;
	endtask

	task automatic requireHits(input string name, input int hits);
		if (hits == 0) begin
			$display("%s check was never reached by the stimulus", name);
			missing++;
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// consumer is busy about a quarter of the cycles
	initial begin
		rngState = RNG_SEED;
		posReady = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			rngState = lcgNext(rngState);
			posReady = (rngState[31:30] != 2'b00);
		end
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("Timeout: no complete flight and exit after %0d cycles", cycleCount);
			$display("Simulation FAILED");
			$finish;
		end
	end

	initial begin
		resetN = 1'b0;
		pause = 1'b0;
		phaseFails = 0;
		missing = 0;
		repeat (4) @(posedge clk);
		#1;
		resetN = 1'b1;
		waitCycles(2);
		finishPhase("reset", i_dut.i_checks.hitReset);

		// let the dragon spawn and cover some distance
		do begin
			waitCycles(1);
		end while (i_dut.i_checks.hitStep < MIN_STEPS);
		finishPhase("flight", i_dut.i_checks.hitStep);

		repeat (PAUSE_WINDOWS) begin
			pause = 1'b1;
			waitCycles(PAUSE_FRAMES * FRAME_CYCLES);
			pause = 1'b0;
			waitCycles(GAP_FRAMES * FRAME_CYCLES);
		end
		finishPhase("pause", i_dut.i_checks.hitHeld);

		do begin
			waitCycles(1);
		end while (i_dut.i_checks.hitExit == 0);
		waitCycles(2 * FRAME_CYCLES);
		finishPhase("exit", i_dut.i_checks.hitExit);

		requireHits("reset", i_dut.i_checks.hitReset);
		requireHits("idle report", i_dut.i_checks.hitIdle);
		requireHits("flight step", i_dut.i_checks.hitStep);
		requireHits("vertical band", i_dut.i_checks.hitBand);
		requireHits("pause hold", i_dut.i_checks.hitHeld);
		requireHits("stall hold", i_dut.i_checks.hitStall);
		requireHits("exit return", i_dut.i_checks.hitExit);
		$write("counts: reset %0d idle %0d step %0d band %0d held %0d",
			i_dut.i_checks.hitReset, i_dut.i_checks.hitIdle, i_dut.i_checks.hitStep,
			i_dut.i_checks.hitBand, i_dut.i_checks.hitHeld);
		$display(" stall %0d exit %0d, %0d failed, %0d unreached",
			i_dut.i_checks.hitStall, i_dut.i_checks.hitExit,
			i_dut.i_checks.failCount, missing);
		if (i_dut.i_checks.failCount == 0 && missing == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* vlog.f */
common/dragonPkg.sv
hw/frameTimer.sv
hw/lfsrRng.sv
dragon/dragonSpawnFsm.sv
dragon/dragonMover.sv
hw/dragonTop.sv
test/dragonTb_assert.sv
test/dragonTb.sv

/* run.sh */
#!/bin/sh
# build and run the dragon testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module dragonTb -f vlog.f -o dragonSim
./obj_dir/dragonSim +verilator+error+limit+100 | tee sim.log
grep -q "Simulation PASSED" sim.log
